// File: flist.f
hw/mem_pkg.sv
hw/byte_ram.sv
hw/mem_ctrl.sv
hw/inst_fetch.sv
hw/lsu_port.sv
hw/mem_top.sv
sim/tb_mem_top.sv

// File: hw/byte_ram.sv
`default_nettype none

module byte_ram #(
    parameter int addr_bits = 12
) (
    input  wire logic                     clk_in,
    input  wire logic [mem_pkg::xlen-1:0] mem_a,
    input  wire logic                     mem_wr,
    input  wire logic [7:0]               mem_dout,
    output logic      [7:0]               mem_din
);

    // one byte per entry
    logic [7:0] mem [2**addr_bits];

    // only the low address bits select an entry
    logic [addr_bits-1:0] idx;

    assign idx = mem_a[addr_bits-1:0];

    always_ff @(posedge clk_in) begin
        if (mem_wr) begin
            mem[idx] <= mem_dout;
        end
        // read every cycle, data shows up one cycle later
        // old contents come back on a write to the same byte
        mem_din <= mem[idx];
    end

endmodule

`default_nettype wire

// File: hw/inst_fetch.sv
`default_nettype none

module inst_fetch #(
    parameter logic [mem_pkg::xlen-1:0] reset_pc = '0
) (
    input  wire logic                     clk_in,
    input  wire logic                     arst_n,
    input  wire logic                     run,
    input  wire logic                     flush,
    input  wire logic [mem_pkg::xlen-1:0] redirect_pc,
    output logic                          fetch_req,
    output logic      [mem_pkg::xlen-1:0] fetch_pc,
    input  wire logic                     fetch_done,
    input  wire mem_pkg::fetch_rsp_t      fetch_rsp,
    output logic                          inst_valid,
    output logic      [mem_pkg::xlen-1:0] inst,
    output logic      [mem_pkg::xlen-1:0] inst_pc
);

    import mem_pkg::*;

    logic [xlen-1:0] pc_q;
    // gap cycle after each delivered word
    logic            hold_q;

    assign fetch_pc  = pc_q;
    assign fetch_req = run && !hold_q;

    // word finishing in a flush cycle belongs to the old path
    assign inst_valid = fetch_done && !flush;
    assign inst       = fetch_rsp.inst;
    assign inst_pc    = fetch_rsp.pc;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            pc_q   <= reset_pc;
            hold_q <= 1'b0;
        end else if (flush) begin
            // redirect, fetch again right away
            pc_q   <= redirect_pc;
            hold_q <= 1'b0;
        end else if (fetch_done) begin
            pc_q   <= pc_q + xlen'(4);
            hold_q <= 1'b1;
        end else begin
            hold_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/lsu_port.sv
`default_nettype none

module lsu_port (
    input  wire logic                     clk_in,
    input  wire logic                     arst_n,
    // external side
    input  wire logic                     req_strobe,
    input  wire mem_pkg::mem_req_t        req,
    output logic                          req_ready,
    // controller side
    output logic                          lsu_valid,
    output mem_pkg::mem_req_t             lsu_req,
    input  wire logic                     lsu_done,
    input  wire logic [mem_pkg::xlen-1:0] load_data,
    // completions
    output logic                          result_valid,
    output logic      [mem_pkg::xlen-1:0] result,
    output logic                          store_done
);

    import mem_pkg::*;

    // single held request
    mem_req_t held_q;
    logic     valid_q;

    assign req_ready = !valid_q;
    assign lsu_valid = valid_q;
    assign lsu_req   = held_q;

    // route the done pulse by access kind
    assign result_valid = lsu_done && !held_q.is_store;
    assign store_done   = lsu_done && held_q.is_store;
    assign result       = load_data;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (lsu_done) begin
            valid_q <= 1'b0;
        end else if (req_strobe && req_ready) begin
            valid_q <= 1'b1;
        end
    end

    // payload only captured when empty
    always_ff @(posedge clk_in) begin
        if (req_strobe && req_ready) begin
            held_q <= req;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_ctrl.sv
`default_nettype none

module mem_ctrl (
    input  wire logic                        clk_in,
    input  wire logic                        arst_n,
    input  wire logic                        flush,
    // load/store client
    input  wire logic                        lsu_valid,
    input  wire mem_pkg::mem_req_t           lsu_req,
    output logic                             lsu_done,
    output logic      [mem_pkg::xlen-1:0]    load_data,
    // fetch client
    input  wire logic                        fetch_req,
    input  wire logic [mem_pkg::xlen-1:0]    fetch_pc,
    output logic                             fetch_done,
    output mem_pkg::fetch_rsp_t              fetch_rsp,
    // byte ram
    output logic      [mem_pkg::xlen-1:0]    mem_a,
    output logic                             mem_wr,
    output logic      [7:0]                  mem_dout,
    input  wire logic [7:0]                  mem_din
);

    import mem_pkg::*;

    ctrl_state_e state;
    // request being worked on, fetches are stored as word loads
    mem_req_t    cur;
    // byte index of the cycle, 1 right after accept
    logic [2:0]  cnt;
    // bytes 0..2 collected so far, byte 3 comes straight from the ram
    logic [23:0] asm_q;
    logic [2:0]  nbytes;
    logic        last;
    logic        accept_lsu;
    logic        accept_fetch;
    logic        fill;

    function automatic logic [2:0] width_bytes(input mem_width_e w);
        case (w)
            width_byte: return 3'd1;
            width_half: return 3'd2;
            default:    return 3'd4;
        endcase
    endfunction

    assign nbytes = width_bytes(cur.width);

    // lsu wins over fetch
    assign accept_lsu   = (state == st_idle) && lsu_valid;
    // no new fetch in a flush cycle, its pc is stale
    assign accept_fetch = (state == st_idle) && !lsu_valid && fetch_req && !flush;

    // final byte is on mem_din
    assign last = (state != st_idle) && (cnt == nbytes);

    // byte address
    always_comb begin
        if (state == st_idle) begin
            // byte 0 goes out in the accept cycle
            mem_a = lsu_valid ? lsu_req.addr : fetch_pc;
        end else begin
            mem_a = cur.addr + xlen'(cnt);
        end
    end

    // write enable and store byte
    always_comb begin
        if (state == st_idle) begin
            mem_wr   = accept_lsu && lsu_req.is_store;
            mem_dout = lsu_req.wdata[7:0];
        end else begin
            mem_wr   = (state == st_store) && (cnt < nbytes);
            // little endian, byte i of the word at addr+i
            mem_dout = cur.wdata[{cnt[1:0], 3'b000} +: 8];
        end
    end

    // final load value, built with the byte arriving now
    always_comb begin
        fill = cur.sign_ext && mem_din[7];
        case (cur.width)
            width_byte: load_data = {{24{fill}}, mem_din};
            width_half: load_data = {{16{fill}}, mem_din, asm_q[7:0]};
            default:    load_data = {mem_din, asm_q};
        endcase
    end

    assign fetch_rsp.inst = {mem_din, asm_q};
    assign fetch_rsp.pc   = cur.addr;

    assign lsu_done   = last && ((state == st_load) || (state == st_store));
    assign fetch_done = last && (state == st_fetch);

    // state and byte counter
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            cnt   <= 3'd0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept_lsu) begin
                        state <= lsu_req.is_store ? st_store : st_load;
                        cnt   <= 3'd1;
                    end else if (accept_fetch) begin
                        state <= st_fetch;
                        cnt   <= 3'd1;
                    end
                end
                st_fetch: begin
                    // flush drops the fetch, no done pulse
                    if (flush || last) begin
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                default: begin
                    // loads and stores always finish
                    if (last) begin
                        state <= st_idle;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
            endcase
        end
    end

    // request latch and byte assembly
    always_ff @(posedge clk_in) begin
        if (accept_lsu) begin
            cur <= lsu_req;
        end else if (accept_fetch) begin
            cur.is_store <= 1'b0;
            cur.width    <= width_word;
            cur.sign_ext <= 1'b0;
            cur.addr     <= fetch_pc;
            cur.wdata    <= '0;
        end
        if (state != st_idle) begin
            // mem_din holds byte cnt-1
            case (cnt)
                3'd1:    asm_q[7:0]   <= mem_din;
                3'd2:    asm_q[15:8]  <= mem_din;
                3'd3:    asm_q[23:16] <= mem_din;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // data and address width of the core
    localparam int xlen = 32;

    // access size, matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        width_byte = 2'b00,
        width_half = 2'b01,
        width_word = 2'b10
    } mem_width_e;

    // one load or store from the core side
    typedef struct packed {
        logic             is_store;
        mem_width_e       width;
        // fill upper bits from the loaded sign bit
        logic             sign_ext;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  wdata;
    } mem_req_t;

    // fetched word with the pc it came from
    typedef struct packed {
        logic [xlen-1:0] inst;
        logic [xlen-1:0] pc;
    } fetch_rsp_t;

    // memory controller owner / direction
    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_fetch = 2'b01,
        st_load  = 2'b10,
        st_store = 2'b11
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/mem_top.sv
`default_nettype none

module mem_top #(
    parameter int                       addr_bits = 12,
    parameter logic [mem_pkg::xlen-1:0] reset_pc  = '0
) (
    input  wire logic                     clk_in,
    input  wire logic                     arst_n,
    // fetch control
    input  wire logic                     run,
    input  wire logic                     flush,
    input  wire logic [mem_pkg::xlen-1:0] redirect_pc,
    // load/store requests
    input  wire logic                     req_strobe,
    input  wire mem_pkg::mem_req_t        req,
    output logic                          req_ready,
    output logic                          result_valid,
    output logic      [mem_pkg::xlen-1:0] result,
    output logic                          store_done,
    // instruction stream
    output logic                          inst_valid,
    output logic      [mem_pkg::xlen-1:0] inst,
    output logic      [mem_pkg::xlen-1:0] inst_pc
);

    import mem_pkg::*;

    // lsu port to controller
    logic            lsu_valid;
    mem_req_t        lsu_req;
    logic            lsu_done;
    logic [xlen-1:0] load_data;

    // fetcher to controller
    logic            fetch_req;
    logic [xlen-1:0] fetch_pc;
    logic            fetch_done;
    fetch_rsp_t      fetch_rsp;

    // controller to ram
    logic [xlen-1:0] mem_a;
    logic            mem_wr;
    logic [7:0]      mem_dout;
    logic [7:0]      mem_din;

    byte_ram #(
        .addr_bits (addr_bits)
    ) u_ram (
        .clk_in   (clk_in),
        .mem_a    (mem_a),
        .mem_wr   (mem_wr),
        .mem_dout (mem_dout),
        .mem_din  (mem_din)
    );

    mem_ctrl u_ctrl (
        .clk_in     (clk_in),
        .arst_n     (arst_n),
        .flush      (flush),
        .lsu_valid  (lsu_valid),
        .lsu_req    (lsu_req),
        .lsu_done   (lsu_done),
        .load_data  (load_data),
        .fetch_req  (fetch_req),
        .fetch_pc   (fetch_pc),
        .fetch_done (fetch_done),
        .fetch_rsp  (fetch_rsp),
        .mem_a      (mem_a),
        .mem_wr     (mem_wr),
        .mem_dout   (mem_dout),
        .mem_din    (mem_din)
    );

    inst_fetch #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk_in      (clk_in),
        .arst_n      (arst_n),
        .run         (run),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_done  (fetch_done),
        .fetch_rsp   (fetch_rsp),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc)
    );

    lsu_port u_lsu (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .req_strobe   (req_strobe),
        .req          (req),
        .req_ready    (req_ready),
        .lsu_valid    (lsu_valid),
        .lsu_req      (lsu_req),
        .lsu_done     (lsu_done),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result       (result),
        .store_done   (store_done)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it; exit status carries the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_mem_top -Mdir obj_dir -f flist.f \
    && ./obj_dir/Vtb_mem_top \
    || { echo "simulation did not pass"; exit 1; }

// File: sim/tb_mem_top.sv
`default_nettype none

module tb_mem_top;

    import mem_pkg::*;

    logic            clk_in;
    logic            arst_n;
    logic            run;
    logic            flush;
    logic [31:0]     redirect_pc;
    logic            req_strobe;
    mem_req_t        req;
    logic            req_ready;
    logic            result_valid;
    logic [31:0]     result;
    logic            store_done;
    logic            inst_valid;
    logic [31:0]     inst;
    logic [31:0]     inst_pc;

    // byte-wise mirror of every store
    logic [7:0]      ref_mem [4096];
    logic [31:0]     rng;
    // next pc the stream must deliver
    logic [31:0]     exp_pc;
    int              inst_count;
    logic [31:0]     word_addrs [$];

    mem_top #(
        .addr_bits (12)
    ) uut (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .run          (run),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .req_strobe   (req_strobe),
        .req          (req),
        .req_ready    (req_ready),
        .result_valid (result_valid),
        .result       (result),
        .store_done   (store_done),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc)
    );

    always #5 clk_in = ~clk_in;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // word aligned, kept clear of the fetch region
    function automatic logic [31:0] rand_addr();
        return 32'h400 + ((next_rand() % 32'hc00) & ~32'h3);
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] a, input mem_width_e w,
                                                input logic sx);
        logic [7:0]  b [4];
        logic [31:0] v;
        for (int i = 0; i < 4; i++) begin
            b[i] = ref_mem[12'(a + 32'(i))];
        end
        case (w)
            width_byte: begin
                v = {24'h0, b[0]};
                // sign bit is bit 7
                if (sx && b[0][7]) v[31:8] = '1;
            end
            width_half: begin
                v = {16'h0, b[1], b[0]};
                if (sx && b[1][7]) v[31:16] = '1;
            end
            default: v = {b[3], b[2], b[1], b[0]};
        endcase
        return v;
    endfunction

    // little endian, byte i lands at a+i
    task automatic write_ref(input logic [31:0] a, input mem_width_e w, input logic [31:0] d);
        int nb;
        nb = (w == width_byte) ? 1 : (w == width_half) ? 2 : 4;
        for (int i = 0; i < nb; i++) begin
            ref_mem[12'(a + 32'(i))] = d[i*8 +: 8];
        end
    endtask

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // instruction stream, sampled on the rising edge
    always @(posedge clk_in) begin
        if (inst_valid) begin
            check_val("inst_pc", inst_pc, exp_pc);
            check_val("inst", inst, expect_load(exp_pc, width_word, 1'b0));
            exp_pc = exp_pc + 32'd4;
            inst_count++;
        end
    end

    // holds strobe for one cycle once the port is free
    task automatic send_req(input mem_req_t r);
        int n;
        n = 0;
        while (!req_ready) begin
            @(negedge clk_in);
            n++;
            if (n > 50) begin
                $display("timeout waiting for req_ready");
                abort_run();
            end
        end
        req        = r;
        req_strobe = 1'b1;
        @(negedge clk_in);
        req_strobe = 1'b0;
    endtask

    task automatic finish_req(input mem_req_t r);
        int n;
        n = 0;
        while (!(result_valid || store_done)) begin
            @(negedge clk_in);
            n++;
            if (n > 50) begin
                $display("timeout waiting for a load/store completion");
                abort_run();
            end
        end
        assert (store_done == r.is_store && result_valid == !r.is_store) else begin
            $display("completion pulse does not match the access kind");
            abort_run();
        end
        if (r.is_store) begin
            write_ref(r.addr, r.width, r.wdata);
        end else begin
            check_val("result", result, expect_load(r.addr, r.width, r.sign_ext));
        end
    endtask

    task automatic access(input logic st, input mem_width_e w, input logic sx,
                          input logic [31:0] a, input logic [31:0] d);
        mem_req_t r;
        r.is_store = st;
        r.width    = w;
        r.sign_ext = sx;
        r.addr     = a;
        r.wdata    = d;
        send_req(r);
        finish_req(r);
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        flush       = 1'b1;
        redirect_pc = pc;
        exp_pc      = pc;
        @(negedge clk_in);
        flush       = 1'b0;
    endtask

    task automatic wait_insts(input int target);
        int n;
        n = 0;
        while (inst_count < target) begin
            @(negedge clk_in);
            n++;
            if (n > 300) begin
                $display("timeout waiting for instructions from the fetcher");
                abort_run();
            end
        end
    endtask

    // a fetch lasts 5 cycles at most, 8 leaves margin
    task automatic stop_fetch();
        run = 1'b0;
        repeat (8) @(negedge clk_in);
    endtask

    task automatic check_reset();
        arst_n = 1'b0;
        for (int i = 0; i < 19; i++) begin
            @(negedge clk_in);
            // release after 16 cycles
            if (i == 15) arst_n = 1'b1;
            check_val("result_valid", 32'(result_valid), 32'h0);
            check_val("store_done", 32'(store_done), 32'h0);
            check_val("inst_valid", 32'(inst_valid), 32'h0);
            check_val("req_ready", 32'(req_ready), 32'h1);
        end
    endtask

    task automatic store_then_load();
        logic [31:0] a;
        for (int i = 0; i < 6; i++) begin
            a = rand_addr();
            access(1'b1, width_word, 1'b0, a, next_rand());
            access(1'b0, width_word, 1'b0, a, 32'h0);
            // sub-word stores merge into the word
            access(1'b1, width_half, 1'b0, a + (next_rand() & 32'h2), next_rand());
            access(1'b1, width_byte, 1'b0, a + (next_rand() & 32'h3), next_rand());
            access(1'b0, width_word, 1'b0, a, 32'h0);
            word_addrs.push_back(a);
        end
    endtask

    task automatic extension();
        logic [31:0] a;
        logic [31:0] d;
        for (int i = 0; i < 6; i++) begin
            a = rand_addr();
            d = next_rand();
            // odd rounds force every top bit
            if (i % 2 == 1) d = d | 32'h8080_8080;
            access(1'b1, width_word, 1'b0, a, d);
            for (int k = 0; k < 4; k++) begin
                access(1'b0, width_byte, 1'b0, a + 32'(k), 32'h0);
                access(1'b0, width_byte, 1'b1, a + 32'(k), 32'h0);
            end
            for (int k = 0; k < 4; k += 2) begin
                access(1'b0, width_half, 1'b0, a + 32'(k), 32'h0);
                access(1'b0, width_half, 1'b1, a + 32'(k), 32'h0);
            end
        end
    endtask

    task automatic fetch_stream();
        for (int i = 0; i < 16; i++) begin
            access(1'b1, width_word, 1'b0, 32'(i * 4), next_rand());
        end
        // pc still at reset_pc
        run = 1'b1;
        wait_insts(inst_count + 8);
        stop_fetch();
    endtask

    task automatic contention();
        redirect_to(32'h0);
        run = 1'b1;
        for (int i = 0; i < 4; i++) begin
            access(1'b0, width_word, 1'b0, word_addrs[next_rand() % 6], 32'h0);
        end
        access(1'b0, width_half, 1'b1, word_addrs[0] + 32'h2, 32'h0);
        wait_insts(inst_count + 2);
        stop_fetch();
    endtask

    task automatic redirect();
        mem_req_t r;
        redirect_to(32'h0);
        run = 1'b1;
        wait_insts(inst_count + 2);
        // gap cycle after the word, the next fetch gets accepted here
        @(negedge clk_in);
        r.is_store = 1'b1;
        r.width    = width_word;
        r.sign_ext = 1'b0;
        r.addr     = rand_addr();
        r.wdata    = next_rand();
        // store waits behind the fetch in flight that the flush drops
        send_req(r);
        redirect_to(32'h20);
        finish_req(r);
        wait_insts(inst_count + 2);
        stop_fetch();
        access(1'b0, width_word, 1'b0, r.addr, 32'h0);
    endtask

    initial begin
        clk_in      = 1'b0;
        arst_n      = 1'b0;
        run         = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        req_strobe  = 1'b0;
        req         = '0;
        rng         = 32'd35819;
        exp_pc      = '0;
        inst_count  = 0;
        check_reset();
        store_then_load();
        extension();
        fetch_stream();
        contention();
        redirect();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
